/* src/mem_pipe_pkg.sv */
package mem_pipe_pkg;

  localparam int DWORD_WIDTH    = 64;
  localparam int DWORD_BYTES    = DWORD_WIDTH / 8;
  localparam int OFFSET_WIDTH   = $clog2(DWORD_BYTES);
  localparam int REG_ADDR_WIDTH = 5;

  // Integer load and store opcodes
  typedef enum logic [3:0]
  {
    op_lb, op_lh, op_lw, op_ld,
    op_lbu, op_lhu, op_lwu,
    op_sb, op_sh, op_sw, op_sd
  } mem_op_e;

  typedef enum logic [1:0]
  {
    size_b, size_h, size_w, size_d
  } mem_size_e;

  typedef struct packed
  {
    logic                      v;
    mem_op_e                   op;
    logic [DWORD_WIDTH-1:0]    rs1;
    logic [DWORD_WIDTH-1:0]    rs2;
    logic [DWORD_WIDTH-1:0]    imm;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
  } mem_req_s;

  // Request after address generation
  typedef struct packed
  {
    logic                      v;
    mem_op_e                   op;
    mem_size_e                 size;
    logic                      store;
    logic [DWORD_WIDTH-1:0]    eaddr;
    logic [DWORD_WIDTH-1:0]    st_data;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
  } mem_stage_s;

  typedef struct packed
  {
    logic                      v;
    mem_op_e                   op;
    logic [OFFSET_WIDTH-1:0]   offset;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [DWORD_WIDTH-1:0]    dword;
  } mem_rdata_s;

  typedef struct packed
  {
    logic load_misaligned;
    logic store_misaligned;
    logic load_access_fault;
    logic store_access_fault;
  } mem_fault_s;

  typedef struct packed
  {
    logic                      v;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [DWORD_WIDTH-1:0]    data;
  } mem_resp_s;

endpackage

/* src/mem_agen.sv */
`timescale 1ns/1ns

module mem_agen
  import mem_pipe_pkg::*;
  (input              clk_i
   , input            reset_i
   , input  mem_req_s req_i
   , output mem_stage_s stage_o
   );

  logic [DWORD_WIDTH-1:0] eaddr;
  mem_size_e              size;
  logic                   store;

  mem_stage_s             stage_r;

  assign eaddr = req_i.rs1 + req_i.imm;
  assign store = req_i.op inside {op_sb, op_sh, op_sw, op_sd};

  always_comb
  begin
    case (req_i.op)
      op_lb, op_lbu, op_sb: size = size_b;
      op_lh, op_lhu, op_sh: size = size_h;
      op_lw, op_lwu, op_sw: size = size_w;
      default:              size = size_d;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      stage_r.v <= 1'b0;
    else
      stage_r.v <= req_i.v;
    stage_r.op      <= req_i.op;
    stage_r.size    <= size;
    stage_r.store   <= store;
    stage_r.eaddr   <= eaddr;
    stage_r.st_data <= req_i.rs2;
    stage_r.rd_addr <= req_i.rd_addr;
  end

  assign stage_o = stage_r;

endmodule

/* src/mem_check.sv */
`timescale 1ns/1ns

module mem_check
  import mem_pipe_pkg::*;
  #(parameter int mem_words_p = 256)
  (input                clk_i
   , input              reset_i
   , input  mem_stage_s stage_i
   , output logic       commit_ok_o
   , output mem_fault_s fault_o
   );

  localparam logic [DWORD_WIDTH-1:0] mem_bytes_lp = DWORD_WIDTH'(mem_words_p) * DWORD_BYTES;

  logic       misaligned;
  logic       access_fault;
  logic       is_load;
  logic       is_store;
  mem_fault_s fault_r;

  always_comb
  begin
    case (stage_i.size)
      size_b:  misaligned = 1'b0;
      size_h:  misaligned = stage_i.eaddr[0];
      size_w:  misaligned = |stage_i.eaddr[1:0];
      default: misaligned = |stage_i.eaddr[2:0];
    endcase
  end

  // Anything past the last doubleword of the local memory faults
  assign access_fault = (stage_i.eaddr >= mem_bytes_lp);

  assign is_load  = stage_i.v & ~stage_i.store;
  assign is_store = stage_i.v &  stage_i.store;

  // Only this block decides whether a store may touch the array
  assign commit_ok_o = is_store & ~misaligned & ~access_fault;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      fault_r <= '0;
    else
    begin
      fault_r.load_misaligned    <= is_load  & misaligned;
      fault_r.store_misaligned   <= is_store & misaligned;
      fault_r.load_access_fault  <= is_load  & access_fault;
      fault_r.store_access_fault <= is_store & access_fault;
    end
  end

  assign fault_o = fault_r;

endmodule

/* src/mem_array.sv */
`timescale 1ns/1ns

module mem_array
  import mem_pipe_pkg::*;
  #(parameter int mem_words_p = 256)
  (input                clk_i
   , input              reset_i
   , input  mem_stage_s stage_i
   , input  logic       commit_ok_i
   , output mem_rdata_s rdata_o
   );

  localparam int idx_width_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1;

  logic [DWORD_WIDTH-1:0]  mem_r [mem_words_p];

  logic [idx_width_lp-1:0] idx;
  logic [OFFSET_WIDTH-1:0] offset;
  logic [DWORD_BYTES-1:0]  size_mask;
  logic [DWORD_BYTES-1:0]  be;
  logic [DWORD_WIDTH-1:0]  wdata;

  mem_rdata_s              rdata_r;

  // High address bits are dropped here, so out of range wraps
  assign idx    = stage_i.eaddr[OFFSET_WIDTH +: idx_width_lp];
  assign offset = stage_i.eaddr[OFFSET_WIDTH-1:0];

  always_comb
  begin
    case (stage_i.size)
      size_b:  size_mask = DWORD_BYTES'(8'h01);
      size_h:  size_mask = DWORD_BYTES'(8'h03);
      size_w:  size_mask = DWORD_BYTES'(8'h0f);
      default: size_mask = DWORD_BYTES'(8'hff);
    endcase
  end

  // Move the store bytes up to their lanes
  assign be    = size_mask << offset;
  assign wdata = stage_i.st_data << {offset, 3'b000};

  always_ff @(posedge clk_i)
  begin
    if (commit_ok_i)
    begin
      for (int b = 0; b < DWORD_BYTES; b++)
      begin
        if (be[b])
          mem_r[idx][b*8 +: 8] <= wdata[b*8 +: 8];
      end
    end
    if (reset_i)
      rdata_r.v <= 1'b0;
    else
      rdata_r.v <= stage_i.v;
    rdata_r.dword   <= mem_r[idx];
    rdata_r.op      <= stage_i.op;
    rdata_r.offset  <= offset;
    rdata_r.rd_addr <= stage_i.rd_addr;
  end

  assign rdata_o = rdata_r;

endmodule

/* src/mem_writeback.sv */
`timescale 1ns/1ns

module mem_writeback
  import mem_pipe_pkg::*;
  (input  mem_rdata_s   rdata_i
   , input  mem_fault_s fault_i
   , output mem_resp_s  load_resp_o
   , output logic       store_done_o
   , output mem_fault_s fault_o
   );

  logic                   is_store;
  logic                   any_fault;
  logic [DWORD_WIDTH-1:0] shifted;
  logic [DWORD_WIDTH-1:0] data;

  assign is_store  = rdata_i.op inside {op_sb, op_sh, op_sw, op_sd};
  assign any_fault = |fault_i;

  // Bring the addressed bytes down to bit 0
  assign shifted = rdata_i.dword >> {rdata_i.offset, 3'b000};

  always_comb
  begin
    case (rdata_i.op)
      op_lb:
        data = {{(DWORD_WIDTH-8){shifted[7]}}, shifted[7:0]};
      op_lh:
        data = {{(DWORD_WIDTH-16){shifted[15]}}, shifted[15:0]};
      op_lw:
        data = {{(DWORD_WIDTH-32){shifted[31]}}, shifted[31:0]};
      op_lbu:
        data = {{(DWORD_WIDTH-8){1'b0}}, shifted[7:0]};
      op_lhu:
        data = {{(DWORD_WIDTH-16){1'b0}}, shifted[15:0]};
      op_lwu:
        data = {{(DWORD_WIDTH-32){1'b0}}, shifted[31:0]};
      default:
        data = shifted;
    endcase
  end

  // A faulting request gives no response
  always_comb
  begin
    load_resp_o.v       = rdata_i.v & ~is_store & ~any_fault;
    load_resp_o.rd_addr = rdata_i.rd_addr;
    load_resp_o.data    = data;
  end

  assign store_done_o = rdata_i.v & is_store & ~any_fault;
  assign fault_o      = fault_i;

endmodule

/* src/mem_pipe.sv */
`timescale 1ns/1ns

module mem_pipe
  import mem_pipe_pkg::*;
  #(parameter int mem_words_p = 256)
  (input                clk_i
   , input              reset_i
   , input  mem_req_s   req_i
   , output mem_resp_s  load_resp_o
   , output logic       store_done_o
   , output mem_fault_s fault_o
   );

  mem_stage_s stage;
  logic       commit_ok;
  mem_fault_s fault;
  mem_rdata_s rdata;

  mem_agen agen
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_i(req_i)
     ,.stage_o(stage)
     );

  mem_check
    #(.mem_words_p(mem_words_p))
    check
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.stage_i(stage)
     ,.commit_ok_o(commit_ok)
     ,.fault_o(fault)
     );

  mem_array
    #(.mem_words_p(mem_words_p))
    array
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.stage_i(stage)
     ,.commit_ok_i(commit_ok)
     ,.rdata_o(rdata)
     );

  mem_writeback writeback
    (.rdata_i(rdata)
     ,.fault_i(fault)
     ,.load_resp_o(load_resp_o)
     ,.store_done_o(store_done_o)
     ,.fault_o(fault_o)
     );

endmodule

/* verif/mem_pipe_assert.sv */
`timescale 1ns/1ns

module mem_pipe_assert
  import mem_pipe_pkg::*;
  (input               clk_i
   , input             reset_i
   , input mem_req_s   req_i
   , input mem_resp_s  load_resp_o
   , input logic       store_done_o
   , input mem_fault_s fault_o
   );

  logic any_out;

  assign any_out = load_resp_o.v | store_done_o | (|fault_o);

  a_one_result: assert property (@(posedge clk_i) disable iff (reset_i)
                                 !(load_resp_o.v && store_done_o))
    else $error("load response and store done are high in the same cycle");

  // Outputs sampled at an edge come from the request sampled two edges back
  a_no_ghost: assert property (@(posedge clk_i) disable iff (reset_i)
                               any_out |-> $past(req_i.v, 2))
    else $error("output activity without a valid request two cycles earlier");

  a_reset_clear: assert property (@(posedge clk_i)
                                  reset_i && $past(reset_i) |-> fault_o == '0)
    else $error("fault flags are set during reset");

endmodule

bind mem_pipe mem_pipe_assert assert_i
  (.clk_i(clk_i)
   ,.reset_i(reset_i)
   ,.req_i(req_i)
   ,.load_resp_o(load_resp_o)
   ,.store_done_o(store_done_o)
   ,.fault_o(fault_o)
   );

/* verif/mem_pipe_tb.sv */
`timescale 1ns/1ns

module mem_pipe_tb
  import mem_pipe_pkg::*;
  ();

  localparam int mem_words_lp = 256;
  localparam int mem_bytes_lp = mem_words_lp * 8;
  localparam int n_rand_lp    = 2000;
  localparam int n_bad_lp     = 100;
  // Worst case counts an idle cycle in front of every random request
  localparam int max_cycles_lp = 8 + 2 * mem_words_lp + 2 * n_rand_lp + 4 * n_bad_lp + 50;

  typedef struct packed
  {
    mem_resp_s  resp;
    logic       store_done;
    mem_fault_s fault;
  } expect_s;

  logic       clk_i;
  logic       reset_i;
  mem_req_s   req_i;
  mem_resp_s  load_resp_o;
  logic       store_done_o;
  mem_fault_s fault_o;

  integer     seed = 12;
  int         cycles = 0;
  logic [7:0] model_mem [mem_bytes_lp];
  expect_s    exp_q [$];

  mem_pipe #(.mem_words_p(mem_words_lp)) dut
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_i(req_i)
     ,.load_resp_o(load_resp_o)
     ,.store_done_o(store_done_o)
     ,.fault_o(fault_o)
     );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > max_cycles_lp)
      report_failure($sformatf("Timeout, the run did not finish in %0d cycles", max_cycles_lp));
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_resp(input mem_resp_s got, input mem_resp_s exp);
    string msg;
    if (got.v !== exp.v || (exp.v && (got.rd_addr !== exp.rd_addr || got.data !== exp.data)))
    begin
      msg = $sformatf("error at %0t ns: load v=%0b rd=%0d data=%h",
                      $time, got.v, got.rd_addr, got.data);
      report_failure($sformatf("%s, expected v=%0b rd=%0d data=%h",
                               msg, exp.v, exp.rd_addr, exp.data));
    end
  endtask

  task automatic check_store(input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("error at %0t ns: store_done_o=%0b, expected %0b", $time, got, exp));
  endtask

  task automatic check_fault(input mem_fault_s got, input mem_fault_s exp);
    if (got !== exp)
      report_failure($sformatf("error at %0t ns: fault_o=%b, expected %b", $time, got, exp));
  endtask

  function automatic int op_bytes(input mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default:              return 8;
    endcase
  endfunction

  function automatic logic op_is_store(input mem_op_e op);
    return op inside {op_sb, op_sh, op_sw, op_sd};
  endfunction

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic mem_op_e random_op();
    return mem_op_e'($unsigned($random(seed)) % 11);
  endfunction

  function automatic logic [63:0] aligned_addr(input int n);
    logic [63:0] a;
    a = 64'($unsigned($random(seed)) % mem_bytes_lp);
    return a - (a % n);
  endfunction

  // Reference model, applied in request order
  task automatic predict(input mem_req_s req, output expect_s e);
    logic [63:0] eaddr;
    logic [63:0] val;
    int          n;
    logic        st;
    logic        mis;
    logic        acc;
    eaddr = req.rs1 + req.imm;
    n     = op_bytes(req.op);
    st    = op_is_store(req.op);
    mis   = (eaddr % n) != 0;
    acc   = eaddr >= mem_bytes_lp;
    e     = '0;
    if (req.v)
    begin
      e.fault.load_misaligned    = ~st & mis;
      e.fault.store_misaligned   = st & mis;
      e.fault.load_access_fault  = ~st & acc;
      e.fault.store_access_fault = st & acc;
      if (!mis && !acc && st)
      begin
        for (int b = 0; b < n; b++)
          model_mem[int'(eaddr) + b] = req.rs2[8*b +: 8];
        e.store_done = 1'b1;
      end
      else if (!mis && !acc)
      begin
        val = '0;
        for (int b = 0; b < n; b++)
          val[8*b +: 8] = model_mem[int'(eaddr) + b];
        if (req.op inside {op_lb, op_lh, op_lw})
          for (int b = 8 * n; b < 64; b++)
            val[b] = val[8*n-1];
        e.resp.v       = 1'b1;
        e.resp.rd_addr = req.rd_addr;
        e.resp.data    = val;
      end
    end
  endtask

  // Outputs seen here belong to the request driven two steps earlier
  task automatic step(input mem_req_s req);
    expect_s e;
    @(posedge clk_i);
    #1;
    e = exp_q.pop_front();
    check_resp(load_resp_o, e.resp);
    check_store(store_done_o, e.store_done);
    check_fault(fault_o, e.fault);
    req_i = req;
    predict(req, e);
    exp_q.push_back(e);
  endtask

  task automatic issue(input mem_op_e op, input logic [63:0] addr, input logic [63:0] data);
    mem_req_s    req;
    logic [11:0] r;
    r           = 12'($random(seed));
    req.v       = 1'b1;
    req.op      = op;
    req.imm     = {{52{r[11]}}, r};
    req.rs1     = addr - req.imm;
    req.rs2     = data;
    req.rd_addr = REG_ADDR_WIDTH'($random(seed));
    step(req);
  endtask

  task automatic idle();
    mem_req_s req;
    req     = '0;
    req.rs1 = rand64();
    req.rs2 = rand64();
    step(req);
  endtask

  initial
  begin
    mem_op_e     op;
    logic [63:0] addr;
    logic [63:0] last_addr;
    int          n;
    req_i   = '0;
    reset_i = 1'b1;
    for (int i = 0; i < 2; i++)
      exp_q.push_back('0);
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    for (int i = 0; i < mem_words_lp; i++)
      issue(op_sd, 64'(i * 8), rand64());
    for (int i = 0; i < mem_words_lp; i++)
      issue(op_ld, 64'(i * 8), rand64());

    // Random traffic, sometimes loading right behind the last access
    last_addr = '0;
    for (int i = 0; i < n_rand_lp; i++)
    begin
      if ($unsigned($random(seed)) % 8 == 0)
        idle();
      op = random_op();
      n  = op_bytes(op);
      if ($unsigned($random(seed)) % 4 == 0 && !op_is_store(op))
        addr = last_addr - (last_addr % n);
      else
        addr = aligned_addr(n);
      issue(op, addr, rand64());
      last_addr = addr;
    end

    for (int i = 0; i < n_bad_lp; i++)
    begin
      do
        op = random_op();
      while (op_bytes(op) == 1);
      n    = op_bytes(op);
      addr = aligned_addr(n) + 1 + $unsigned($random(seed)) % (n - 1);
      issue(op, addr, rand64());
      issue(op_ld, addr & ~64'h7, rand64());
    end

    for (int i = 0; i < n_bad_lp; i++)
    begin
      op   = random_op();
      n    = op_bytes(op);
      addr = mem_bytes_lp + $unsigned($random(seed));
      if ($random(seed) & 1)
        addr = addr - (addr % n);
      issue(op, addr, rand64());
    end

    repeat (3) idle();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* mem_pipe.f */
src/mem_pipe_pkg.sv
src/mem_agen.sv
src/mem_check.sv
src/mem_array.sv
src/mem_writeback.sv
src/mem_pipe.sv
verif/mem_pipe_assert.sv
verif/mem_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mem_pipe_tb \
  -f mem_pipe.f -o mem_pipe_sim

# The log decides the result
./obj_dir/mem_pipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation ended without a pass report"
  exit 1
fi
